// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_core
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it, log to $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "Finished with no errors" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/tb_core.sv ====
`timescale 1ns/100ps

module tb_core;

  localparam int n_fixed = 34;
  localparam int n_random = 22;
  localparam int n_rows = n_fixed + n_random;
  // rows x 12 instructions x 3 cycles x 4 ns plus both resets and the halt checks
  localparam int timeout_ns = n_rows * 12 * 3 * 4 + 1000;
  localparam logic [31:0] result_base = 32'h0000_1000;
  localparam logic [31:0] scratch_addr = 32'h0000_0ffc;

  typedef enum int {
    k_add, k_sub, k_sll, k_slt, k_sltu, k_xor, k_srl, k_sra, k_or, k_and,
    k_addi, k_slti, k_sltiu, k_xori, k_ori, k_andi, k_slli, k_srli, k_srai,
    k_lui, k_auipc, k_beq, k_bne, k_blt, k_bge, k_bltu, k_bgeu,
    k_jal, k_jalr, k_lw
  } kind_t;

  logic clk;
  logic rst;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_rdata;
  logic [31:0] dmem_wdata;
  logic dmem_we;
  logic halt;
  logic illegal;

  logic [31:0] mem [0:4095];
  kind_t row_kind [$];
  logic [31:0] row_a [$];
  logic [31:0] row_b [$];
  logic [31:0] row_exp [$];
  // every store the program should make, in program order
  logic [31:0] exp_addr_q [$];
  logic [31:0] exp_data_q [$];
  logic [31:0] prog_addr;
  logic [31:0] ecall_addr;
  logic [31:0] rnd;
  int errors;
  int checks;
  int store_idx;

  rv_core uut (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_addr  (dmem_addr),
    .dmem_rdata (dmem_rdata),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .halt       (halt),
    .illegal    (illegal)
  );

  always #2 clk = ~clk;

  // memory samples on the falling edge so the word is ready for the next cycle
  always @(negedge clk) begin
    if (!rst && dmem_we === 1'b1) begin
      mem[dmem_addr[13:2]] = dmem_wdata;
    end
    imem_data <= mem[imem_addr[13:2]];
    dmem_rdata <= mem[dmem_addr[13:2]];
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    errors++;
    $display("FAIL %s: got %h expected %h", name, got, want);
  endtask

  // store monitor
  always @(negedge clk) begin
    if (!rst && dmem_we === 1'b1) begin
      if (exp_addr_q.size() == 0) begin
        errors++;
        $display("ERROR: unexpected store of %h to %h after the last expected store",
                 dmem_wdata, dmem_addr);
      end else begin
        checks++;
        if (dmem_addr !== exp_addr_q[0]) begin
          report_mismatch("dmem_addr", dmem_addr, exp_addr_q[0]);
        end
        if (dmem_wdata !== exp_data_q[0]) begin
          $display("store %0d at %h", store_idx, exp_addr_q[0]);
          report_mismatch("dmem_wdata", dmem_wdata, exp_data_q[0]);
        end
        exp_addr_q.delete(0);
        exp_data_q.delete(0);
        store_idx++;
      end
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // RV32I result of one row with auipc, jal and jalr relative to the insn address
  function automatic logic [31:0] ref_result(input kind_t kind, input logic [31:0] a,
                                             input logic [31:0] b);
    logic [31:0] bi;
    logic [4:0] sa;
    logic [31:0] r;
    bi = {{20{b[11]}}, b[11:0]};
    sa = b[4:0];
    case (kind)
      k_add: r = a + b;
      k_sub: r = a - b;
      k_sll: r = a << sa;
      k_slt: r = {31'd0, $signed(a) < $signed(b)};
      k_sltu: r = {31'd0, a < b};
      k_xor: r = a ^ b;
      k_srl: r = a >> sa;
      k_sra: r = $signed(a) >>> sa;
      k_or: r = a | b;
      k_and: r = a & b;
      k_addi: r = a + bi;
      k_slti: r = {31'd0, $signed(a) < $signed(bi)};
      k_sltiu: r = {31'd0, a < bi};
      k_xori: r = a ^ bi;
      k_ori: r = a | bi;
      k_andi: r = a & bi;
      k_slli: r = a << sa;
      k_srli: r = a >> sa;
      k_srai: r = $signed(a) >>> sa;
      k_lui, k_auipc: r = {b[19:0], 12'h000};
      k_beq: r = (a == b) ? 32'd2 : 32'd1;
      k_bne: r = (a != b) ? 32'd2 : 32'd1;
      k_blt: r = ($signed(a) < $signed(b)) ? 32'd2 : 32'd1;
      k_bge: r = ($signed(a) >= $signed(b)) ? 32'd2 : 32'd1;
      k_bltu: r = (a < b) ? 32'd2 : 32'd1;
      k_bgeu: r = (a >= b) ? 32'd2 : 32'd1;
      k_jal, k_jalr: r = 32'd4;
      default: r = a + b;
    endcase
    return r;
  endfunction

  function automatic logic [2:0] funct3_of(input kind_t kind);
    case (kind)
      k_sll, k_slli: return rv_pkg::f3_sll;
      k_slt, k_slti: return rv_pkg::f3_slt;
      k_sltu, k_sltiu: return rv_pkg::f3_sltu;
      k_xor, k_xori: return rv_pkg::f3_xor;
      k_srl, k_sra, k_srli, k_srai: return rv_pkg::f3_srl;
      k_or, k_ori: return rv_pkg::f3_or;
      k_and, k_andi: return rv_pkg::f3_and;
      k_bne: return rv_pkg::f3_bne;
      k_blt: return rv_pkg::f3_blt;
      k_bge: return rv_pkg::f3_bge;
      k_bltu: return rv_pkg::f3_bltu;
      k_bgeu: return rv_pkg::f3_bgeu;
      default: return 3'b000;
    endcase
  endfunction

  task automatic add_row(input kind_t kind, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] exp);
    row_kind.push_back(kind);
    row_a.push_back(a);
    row_b.push_back(b);
    row_exp.push_back(exp);
  endtask

  task automatic emit(input logic [31:0] word);
    mem[prog_addr[13:2]] = word;
    prog_addr = prog_addr + 32'd4;
  endtask

  // lui + addi with the upper part rounded for the sign of the low 12 bits
  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] hi;
    hi = value + 32'h800;
    emit({hi[31:12], rd, rv_pkg::op_lui});
    emit({value[11:0], rd, 3'b000, rd, rv_pkg::op_reg_imm});
  endtask

  // sw rs2 into the result area based at x4
  task automatic store_word(input logic [4:0] rs2, input logic [11:0] offs);
    emit({offs[11:5], rs2, 5'd4, rv_pkg::f3_word, offs[4:0], rv_pkg::op_store});
  endtask

  task automatic emit_jal(input logic [4:0] rd, input logic [20:0] offs);
    emit({offs[20], offs[10:1], offs[11], offs[19:12], rd, rv_pkg::op_jal});
  endtask

  task automatic build_row(input int idx);
    kind_t kind;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp;
    logic [31:0] here;
    logic [11:0] slot;
    logic [6:0] f7;
    logic [2:0] f3;
    kind = row_kind[idx];
    a = row_a[idx];
    b = row_b[idx];
    exp = row_exp[idx];
    slot = 12'(idx * 4);
    f3 = funct3_of(kind);
    f7 = (kind == k_sub || kind == k_sra || kind == k_srai) ? rv_pkg::f7_alt : rv_pkg::f7_base;
    load_const(5'd1, a);
    load_const(5'd2, b);
    here = prog_addr;
    if (kind <= k_and) begin
      emit({f7, 5'd2, 5'd1, f3, 5'd3, rv_pkg::op_reg_reg});
    end else if (kind == k_slli || kind == k_srli || kind == k_srai) begin
      emit({f7, b[4:0], 5'd1, f3, 5'd3, rv_pkg::op_reg_imm});
    end else if (kind <= k_andi) begin
      emit({b[11:0], 5'd1, f3, 5'd3, rv_pkg::op_reg_imm});
    end else if (kind == k_lui) begin
      emit({b[19:0], 5'd3, rv_pkg::op_lui});
    end else if (kind == k_auipc) begin
      exp = exp + here;
      emit({b[19:0], 5'd3, rv_pkg::op_auipc});
    end else if (kind <= k_bgeu) begin
      // taken branch lands on addi x3,2 and the fall-through sets 1 then jumps over it
      emit({1'b0, 6'd0, 5'd2, 5'd1, f3, 4'd6, 1'b0, rv_pkg::op_branch});
      emit({12'd1, 5'd0, 3'b000, 5'd3, rv_pkg::op_reg_imm});
      emit_jal(5'd0, 21'd8);
      emit({12'd2, 5'd0, 3'b000, 5'd3, rv_pkg::op_reg_imm});
    end else if (kind == k_jal) begin
      exp = exp + here;
      emit_jal(5'd3, 21'd8);
      store_word(5'd0, slot);
    end else if (kind == k_jalr) begin
      // target +1 so bit 0 has to be dropped
      load_const(5'd5, here + 32'd16);
      exp = exp + here + 32'd8;
      emit({12'd1, 5'd5, 3'b000, 5'd3, rv_pkg::op_jalr});
      store_word(5'd0, slot);
    end else begin
      store_word(5'd1, 12'hffc);
      exp_addr_q.push_back(scratch_addr);
      exp_data_q.push_back(a);
      emit({12'hffc, 5'd4, rv_pkg::f3_word, 5'd3, rv_pkg::op_load});
      emit({rv_pkg::f7_base, 5'd2, 5'd3, 3'b000, 5'd3, rv_pkg::op_reg_reg});
    end
    store_word(5'd3, slot);
    exp_addr_q.push_back(result_base + 32'(idx * 4));
    exp_data_q.push_back(exp);
  endtask

  task automatic wait_halt();
    while (halt !== 1'b1) begin
      @(negedge clk);
    end
  endtask

  initial begin
    #(timeout_ns);
    $display("ERROR: timeout after %0d ns, the core never reached halt", timeout_ns);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    kind_t kind;
    logic [31:0] a;
    logic [31:0] b;
    clk = 1'b0;
    rst <= 1'b1;
    imem_data <= '0;
    dmem_rdata <= '0;
    errors = 0;
    checks = 0;
    store_idx = 0;
    rnd = 32'h72e1_d051;
    for (int w = 0; w < 4096; w++) begin
      mem[w[11:0]] = {w[11:0], 8'h5a, ~w[11:0]};
    end

    // edge rows for zero, all ones, sign bit and shift 31
    add_row(k_add, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000);
    add_row(k_add, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000);
    add_row(k_sub, 32'h0000_0000, 32'h0000_0001, 32'hffff_ffff);
    add_row(k_sub, 32'h8000_0000, 32'h0000_0001, 32'h7fff_ffff);
    add_row(k_sll, 32'h0000_0001, 32'h0000_001f, 32'h8000_0000);
    add_row(k_sll, 32'hffff_ffff, 32'h0000_0021, 32'hffff_fffe);
    add_row(k_slt, 32'h8000_0000, 32'h0000_0000, 32'h0000_0001);
    add_row(k_slt, 32'h0000_0000, 32'hffff_ffff, 32'h0000_0000);
    add_row(k_sltu, 32'h0000_0000, 32'hffff_ffff, 32'h0000_0001);
    add_row(k_xor, 32'hffff_ffff, 32'h0000_0000, 32'hffff_ffff);
    add_row(k_srl, 32'h8000_0000, 32'h0000_001f, 32'h0000_0001);
    add_row(k_sra, 32'h8000_0000, 32'h0000_001f, 32'hffff_ffff);
    add_row(k_or, 32'h8000_0000, 32'h0000_0001, 32'h8000_0001);
    add_row(k_and, 32'hffff_ffff, 32'h8000_0000, 32'h8000_0000);
    add_row(k_addi, 32'h0000_0001, 32'h0000_0fff, 32'h0000_0000);
    add_row(k_slti, 32'h0000_0000, 32'h0000_0800, 32'h0000_0000);
    add_row(k_sltiu, 32'h0000_0000, 32'h0000_0fff, 32'h0000_0001);
    add_row(k_xori, 32'h0f0f_0f0f, 32'h0000_0fff, 32'hf0f0_f0f0);
    add_row(k_ori, 32'h0000_0000, 32'h0000_0800, 32'hffff_f800);
    add_row(k_andi, 32'hffff_ffff, 32'h0000_07ff, 32'h0000_07ff);
    add_row(k_slli, 32'h0000_0001, 32'h0000_001f, 32'h8000_0000);
    add_row(k_srli, 32'hffff_ffff, 32'h0000_001f, 32'h0000_0001);
    add_row(k_srai, 32'h8000_0000, 32'h0000_001f, 32'hffff_ffff);
    add_row(k_lui, 32'h0000_0000, 32'h0008_0000, 32'h8000_0000);
    add_row(k_auipc, 32'h0000_0000, 32'h0000_0001, 32'h0000_1000);
    add_row(k_beq, 32'h0000_0005, 32'h0000_0005, 32'h0000_0002);
    add_row(k_bne, 32'h0000_0005, 32'h0000_0005, 32'h0000_0001);
    add_row(k_blt, 32'hffff_ffff, 32'h0000_0000, 32'h0000_0002);
    add_row(k_bge, 32'h8000_0000, 32'h7fff_ffff, 32'h0000_0001);
    add_row(k_bltu, 32'hffff_ffff, 32'h0000_0000, 32'h0000_0001);
    add_row(k_bgeu, 32'hffff_ffff, 32'h0000_0000, 32'h0000_0002);
    add_row(k_jal, 32'h0000_0000, 32'h0000_0000, 32'h0000_0004);
    add_row(k_jalr, 32'h0000_0000, 32'h0000_0000, 32'h0000_0004);
    add_row(k_lw, 32'hdead_beef, 32'h0000_0001, 32'hdead_bef0);
    for (int r = 0; r < n_random; r++) begin
      rnd = xorshift32(rnd);
      kind = kind_t'(int'(rnd % 32'd30));
      rnd = xorshift32(rnd);
      a = rnd;
      rnd = xorshift32(rnd);
      b = rnd;
      add_row(kind, a, b, ref_result(kind, a, b));
    end

    // x4 holds the result area base and each row gets a short program
    prog_addr = '0;
    emit({20'h00001, 5'd4, rv_pkg::op_lui});
    for (int i = 0; i < row_kind.size(); i++) begin
      build_row(i);
    end
    ecall_addr = prog_addr;
    emit(32'h0000_0073);

    repeat (10) @(negedge clk);
    rst <= 1'b0;
    wait_halt();
    if (exp_addr_q.size() != 0) begin
      errors++;
      $display("ERROR: %0d expected stores never happened", exp_addr_q.size());
    end
    if (illegal !== 1'b0) begin
      report_mismatch("illegal", {31'd0, illegal}, 32'd0);
    end
    repeat (5) @(negedge clk);
    if (halt !== 1'b1) begin
      report_mismatch("halt", {31'd0, halt}, 32'd1);
    end
    if (imem_addr !== ecall_addr) begin
      report_mismatch("imem_addr", imem_addr, ecall_addr);
    end

    // second run on an all-zero word
    rst <= 1'b1;
    mem[0] = 32'h0000_0000;
    repeat (10) @(negedge clk);
    rst <= 1'b0;
    wait_halt();
    repeat (5) @(negedge clk);
    if (illegal !== 1'b1) begin
      report_mismatch("illegal", {31'd0, illegal}, 32'd1);
    end
    if (halt !== 1'b1) begin
      report_mismatch("halt", {31'd0, halt}, 32'd1);
    end
    if (imem_addr !== 32'h0000_0000) begin
      report_mismatch("imem_addr", imem_addr, 32'h0000_0000);
    end

    $display("stores checked %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== common/rv_pkg.sv ====
package rv_pkg;

  // widths fixed by RV32I
  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // major opcodes
  localparam logic [6:0] op_load = 7'b00_000_11;
  localparam logic [6:0] op_store = 7'b01_000_11;
  localparam logic [6:0] op_branch = 7'b11_000_11;
  localparam logic [6:0] op_jalr = 7'b11_001_11;
  localparam logic [6:0] op_jal = 7'b11_011_11;
  localparam logic [6:0] op_reg_imm = 7'b00_100_11;
  localparam logic [6:0] op_reg_reg = 7'b01_100_11;
  localparam logic [6:0] op_system = 7'b11_100_11;
  localparam logic [6:0] op_auipc = 7'b00_101_11;
  localparam logic [6:0] op_lui = 7'b01_101_11;

  // alu funct3
  localparam logic [2:0] f3_add = 3'b000;
  localparam logic [2:0] f3_sll = 3'b001;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_srl = 3'b101;
  localparam logic [2:0] f3_or = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;

  // branch funct3
  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;
  localparam logic [2:0] f3_blt = 3'b100;
  localparam logic [2:0] f3_bge = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // only word accesses are kept
  localparam logic [2:0] f3_word = 3'b010;

  localparam logic [6:0] f7_base = 7'h00;
  localparam logic [6:0] f7_alt = 7'h20;

  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_sll    = 4'd2,
    alu_slt    = 4'd3,
    alu_sltu   = 4'd4,
    alu_xor    = 4'd5,
    alu_srl    = 4'd6,
    alu_sra    = 4'd7,
    alu_or     = 4'd8,
    alu_and    = 4'd9,
    alu_pass_b = 4'd10
  } alu_op_t;

  typedef enum logic [2:0] {
    cls_alu     = 3'd0,
    cls_branch  = 3'd1,
    cls_jal     = 3'd2,
    cls_jalr    = 3'd3,
    cls_load    = 3'd4,
    cls_store   = 3'd5,
    cls_system  = 3'd6,
    cls_illegal = 3'd7
  } insn_class_t;

  typedef enum logic [1:0] {
    st_fetch     = 2'd0,
    st_execute   = 2'd1,
    st_load_wait = 2'd2,
    st_halted    = 2'd3
  } ctrl_state_t;

  localparam word_t pc_step = 32'd4;
  localparam word_t reset_pc = 32'd0;

endpackage

// ==== files.f ====
common/rv_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/insn_decoder.sv
hw/pc_unit.sv
hw/core_ctrl.sv
hw/rv_core.sv
bench/tb_core.sv

// ==== hw/alu.sv ====
`timescale 1ns/100ps

module alu (
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  rv_pkg::alu_op_t op,
  input  logic [2:0]      funct3,
  output rv_pkg::word_t   result,
  output logic            branch_taken
);

  logic [4:0] shamt;
  logic lt_signed;
  logic lt_unsigned;

  assign shamt = b[4:0];
  assign lt_signed = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      rv_pkg::alu_add: result = a + b;
      rv_pkg::alu_sub: result = a - b;
      rv_pkg::alu_sll: result = a << shamt;
      rv_pkg::alu_slt: result = {31'd0, lt_signed};
      rv_pkg::alu_sltu: result = {31'd0, lt_unsigned};
      rv_pkg::alu_xor: result = a ^ b;
      rv_pkg::alu_srl: result = a >> shamt;
      rv_pkg::alu_sra: result = $unsigned($signed(a) >>> shamt);
      rv_pkg::alu_or: result = a | b;
      rv_pkg::alu_and: result = a & b;
      rv_pkg::alu_pass_b: result = b;
      default: result = a + b;
    endcase
  end

  // condition only matters for branch class
  always_comb begin
    case (funct3)
      rv_pkg::f3_beq: branch_taken = a == b;
      rv_pkg::f3_bne: branch_taken = a != b;
      rv_pkg::f3_blt: branch_taken = lt_signed;
      rv_pkg::f3_bge: branch_taken = !lt_signed;
      rv_pkg::f3_bltu: branch_taken = lt_unsigned;
      rv_pkg::f3_bgeu: branch_taken = !lt_unsigned;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

// ==== hw/core_ctrl.sv ====
`timescale 1ns/100ps

module core_ctrl (
  input  logic                clk,
  input  logic                rst,
  input  rv_pkg::insn_class_t insn_class,
  output logic                pc_we,
  output logic                rd_we,
  output logic                dmem_we,
  output logic                halt,
  output logic                illegal,
  output logic                rd_from_mem
);

  rv_pkg::ctrl_state_t state;
  rv_pkg::ctrl_state_t state_next;
  logic in_execute;
  logic in_load_wait;
  logic stops;

  assign in_execute = state == rv_pkg::st_execute;
  assign in_load_wait = state == rv_pkg::st_load_wait;
  assign stops = insn_class == rv_pkg::cls_system || insn_class == rv_pkg::cls_illegal;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rv_pkg::st_fetch;
      illegal <= 1'b0;
    end else begin
      state <= state_next;
      // sticky until reset
      if (in_execute && insn_class == rv_pkg::cls_illegal) begin
        illegal <= 1'b1;
      end
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      rv_pkg::st_fetch: state_next = rv_pkg::st_execute;
      rv_pkg::st_execute: begin
        if (insn_class == rv_pkg::cls_load) begin
          state_next = rv_pkg::st_load_wait;
        end else if (stops) begin
          state_next = rv_pkg::st_halted;
        end else begin
          state_next = rv_pkg::st_fetch;
        end
      end
      rv_pkg::st_load_wait: state_next = rv_pkg::st_fetch;
      default: state_next = rv_pkg::st_halted;
    endcase
  end

  // loads retire in load wait and halting insns keep the pc
  assign pc_we = (in_execute && insn_class != rv_pkg::cls_load && !stops) || in_load_wait;
  assign rd_we = (in_execute && (insn_class == rv_pkg::cls_alu ||
                                 insn_class == rv_pkg::cls_jal ||
                                 insn_class == rv_pkg::cls_jalr)) || in_load_wait;
  assign dmem_we = in_execute && insn_class == rv_pkg::cls_store;
  assign rd_from_mem = in_load_wait;
  assign halt = state == rv_pkg::st_halted;

  // store strobe never overlaps the load wait
  a_store_not_in_load_wait: assert property (@(posedge clk) disable iff (rst)
    !(dmem_we && in_load_wait));

endmodule

// ==== hw/insn_decoder.sv ====
`timescale 1ns/100ps

module insn_decoder (
  input  rv_pkg::word_t       insn,
  output rv_pkg::reg_addr_t   rs1_addr,
  output rv_pkg::reg_addr_t   rs2_addr,
  output rv_pkg::reg_addr_t   rd_addr,
  output rv_pkg::word_t       imm,
  output rv_pkg::alu_op_t     alu_op,
  output logic                use_imm,
  output logic                use_pc,
  output rv_pkg::insn_class_t insn_class
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rv_pkg::word_t imm_i;
  rv_pkg::word_t imm_s;
  rv_pkg::word_t imm_b;
  rv_pkg::word_t imm_j;
  rv_pkg::word_t imm_u;

  // shared by reg-reg and reg-imm forms
  function automatic rv_pkg::alu_op_t base_op(input logic [2:0] f3);
    case (f3)
      rv_pkg::f3_sll: return rv_pkg::alu_sll;
      rv_pkg::f3_slt: return rv_pkg::alu_slt;
      rv_pkg::f3_sltu: return rv_pkg::alu_sltu;
      rv_pkg::f3_xor: return rv_pkg::alu_xor;
      rv_pkg::f3_srl: return rv_pkg::alu_srl;
      rv_pkg::f3_or: return rv_pkg::alu_or;
      rv_pkg::f3_and: return rv_pkg::alu_and;
      default: return rv_pkg::alu_add;
    endcase
  endfunction

  assign opcode = insn[6:0];
  assign rd_addr = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1_addr = insn[19:15];
  assign rs2_addr = insn[24:20];
  assign funct7 = insn[31:25];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    imm = '0;
    alu_op = rv_pkg::alu_add;
    use_imm = 1'b0;
    use_pc = 1'b0;
    insn_class = rv_pkg::cls_illegal;
    case (opcode)
      rv_pkg::op_reg_reg: begin
        if (funct7 == rv_pkg::f7_base) begin
          insn_class = rv_pkg::cls_alu;
          alu_op = base_op(funct3);
        end else if (funct7 == rv_pkg::f7_alt && funct3 == rv_pkg::f3_add) begin
          insn_class = rv_pkg::cls_alu;
          alu_op = rv_pkg::alu_sub;
        end else if (funct7 == rv_pkg::f7_alt && funct3 == rv_pkg::f3_srl) begin
          insn_class = rv_pkg::cls_alu;
          alu_op = rv_pkg::alu_sra;
        end
      end
      rv_pkg::op_reg_imm: begin
        imm = imm_i;
        use_imm = 1'b1;
        alu_op = base_op(funct3);
        insn_class = rv_pkg::cls_alu;
        // shift immediates carry funct7 in the upper bits
        if (funct3 == rv_pkg::f3_sll && funct7 != rv_pkg::f7_base) begin
          insn_class = rv_pkg::cls_illegal;
        end else if (funct3 == rv_pkg::f3_srl) begin
          if (funct7 == rv_pkg::f7_alt) begin
            alu_op = rv_pkg::alu_sra;
          end else if (funct7 != rv_pkg::f7_base) begin
            insn_class = rv_pkg::cls_illegal;
          end
        end
      end
      rv_pkg::op_lui: begin
        imm = imm_u;
        use_imm = 1'b1;
        alu_op = rv_pkg::alu_pass_b;
        insn_class = rv_pkg::cls_alu;
      end
      rv_pkg::op_auipc: begin
        imm = imm_u;
        use_imm = 1'b1;
        use_pc = 1'b1;
        insn_class = rv_pkg::cls_alu;
      end
      rv_pkg::op_load: begin
        imm = imm_i;
        use_imm = 1'b1;
        if (funct3 == rv_pkg::f3_word) begin
          insn_class = rv_pkg::cls_load;
        end
      end
      rv_pkg::op_store: begin
        imm = imm_s;
        use_imm = 1'b1;
        if (funct3 == rv_pkg::f3_word) begin
          insn_class = rv_pkg::cls_store;
        end
      end
      rv_pkg::op_branch: begin
        // alu sees rs1/rs2 raw, target is formed in pc_unit
        imm = imm_b;
        if (funct3 != 3'b010 && funct3 != 3'b011) begin
          insn_class = rv_pkg::cls_branch;
        end
      end
      rv_pkg::op_jal: begin
        imm = imm_j;
        insn_class = rv_pkg::cls_jal;
      end
      rv_pkg::op_jalr: begin
        imm = imm_i;
        use_imm = 1'b1;
        if (funct3 == 3'b000) begin
          insn_class = rv_pkg::cls_jalr;
        end
      end
      rv_pkg::op_system: begin
        // ecall only
        if (insn[31:7] == 25'd0) begin
          insn_class = rv_pkg::cls_system;
        end
      end
      default: insn_class = rv_pkg::cls_illegal;
    endcase
  end

endmodule

// ==== hw/pc_unit.sv ====
`timescale 1ns/100ps

module pc_unit (
  input  logic                clk,
  input  logic                rst,
  input  logic                pc_we,
  input  rv_pkg::insn_class_t insn_class,
  input  logic                branch_taken,
  input  rv_pkg::word_t       imm,
  input  rv_pkg::word_t       jalr_target,
  output rv_pkg::word_t       pc,
  output rv_pkg::word_t       pc_plus4
);

  rv_pkg::word_t pc_next;

  assign pc_plus4 = pc + rv_pkg::pc_step;

  always_comb begin
    pc_next = pc_plus4;
    if (insn_class == rv_pkg::cls_jal ||
        (insn_class == rv_pkg::cls_branch && branch_taken)) begin
      pc_next = pc + imm;
    end else if (insn_class == rv_pkg::cls_jalr) begin
      pc_next = {jalr_target[31:1], 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= rv_pkg::reset_pc;
    end else if (pc_we) begin
      pc <= pc_next;
    end
  end

  // every taken target has to land on a word boundary
  a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
    pc_we |=> pc[1:0] == 2'b00);

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rs2_addr,
  input  rv_pkg::reg_addr_t rd_addr,
  input  rv_pkg::word_t     rd_data,
  input  logic              we,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data
);

  // x0 has no storage
  rv_pkg::word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_addr != 5'd0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/100ps

module rv_core (
  input  logic          clk,
  input  logic          rst,
  output rv_pkg::word_t imem_addr,
  input  rv_pkg::word_t imem_data,
  output rv_pkg::word_t dmem_addr,
  input  rv_pkg::word_t dmem_rdata,
  output rv_pkg::word_t dmem_wdata,
  output logic          dmem_we,
  output logic          halt,
  output logic          illegal
);

  rv_pkg::reg_addr_t rs1_addr;
  rv_pkg::reg_addr_t rs2_addr;
  rv_pkg::reg_addr_t rd_addr;
  rv_pkg::word_t imm;
  rv_pkg::alu_op_t alu_op;
  rv_pkg::insn_class_t insn_class;
  logic use_imm;
  logic use_pc;

  rv_pkg::word_t pc;
  rv_pkg::word_t pc_plus4;
  rv_pkg::word_t rs1_data;
  rv_pkg::word_t rs2_data;
  rv_pkg::word_t alu_a;
  rv_pkg::word_t alu_b;
  rv_pkg::word_t alu_result;
  rv_pkg::word_t rd_data;
  logic branch_taken;
  logic pc_we;
  logic rd_we;
  logic rd_from_mem;

  // operand selection
  assign alu_a = use_pc ? pc : rs1_data;
  assign alu_b = use_imm ? imm : rs2_data;

  // write-back source: memory, link address or alu
  assign rd_data = rd_from_mem ? dmem_rdata :
                   (insn_class == rv_pkg::cls_jal || insn_class == rv_pkg::cls_jalr) ?
                   pc_plus4 : alu_result;

  assign imem_addr = pc;
  assign dmem_addr = alu_result;
  assign dmem_wdata = rs2_data;

  core_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .insn_class  (insn_class),
    .pc_we       (pc_we),
    .rd_we       (rd_we),
    .dmem_we     (dmem_we),
    .halt        (halt),
    .illegal     (illegal),
    .rd_from_mem (rd_from_mem)
  );

  pc_unit u_pc (
    .clk          (clk),
    .rst          (rst),
    .pc_we        (pc_we),
    .insn_class   (insn_class),
    .branch_taken (branch_taken),
    .imm          (imm),
    .jalr_target  (alu_result),
    .pc           (pc),
    .pc_plus4     (pc_plus4)
  );

  insn_decoder u_dec (
    .insn       (imem_data),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .rd_addr    (rd_addr),
    .imm        (imm),
    .alu_op     (alu_op),
    .use_imm    (use_imm),
    .use_pc     (use_pc),
    .insn_class (insn_class)
  );

  reg_file u_rf (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .we       (rd_we),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu u_alu (
    .a            (alu_a),
    .b            (alu_b),
    .op           (alu_op),
    .funct3       (imem_data[14:12]),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

endmodule
